// File: list.f
src/fetch_pkg.sv
src/fetch_fifo.sv
src/prefetch_ctrl.sv
src/prefetch_buffer.sv
src/if_stage.sv
src/fetch_top.sv
sim/tb_instr_mem.sv
sim/tb_fetch_top.sv

// File: sim/tb_fetch_top.sv
// fetch_top testbench; FIFO depth 2, memory data is addr ^ 32'hA5A5_0000, checks are assertions
`timescale 1ns/100ps

module tb_fetch_top;

  import fetch_pkg::*;

  localparam int          CLK_PERIOD = 20;
  localparam int          RESET_CYC  = 10;
  localparam int          FIFO_DEPTH = 2;
  localparam logic [31:0] SEED       = 32'h3a3d;
  localparam logic [31:0] DATA_XOR   = 32'hA5A5_0000;
  localparam int          TEST_WORDS = 8 + 40 + 21 + 30 + 200 + 12; // word budget of all tests
  localparam int          WORST_CYC  = 24; // gnt wait + delay + stalls per word, generous

  localparam logic [31:0] BOOT_ADDR  = 32'h0000_1002; // low bits dropped by the fetch
  localparam logic [23:0] MTVEC_BASE = 24'h00_0020;
  localparam logic [4:0]  VEC_IDX    = 5'd11;
  localparam logic [29:0] DM_HALT    = 30'h0000_0C00;
  localparam logic [29:0] DM_EXC     = 30'h0000_0C04;
  localparam logic [31:0] MEPC       = 32'h0000_4000;
  localparam logic [31:0] DEPC       = 32'h0000_5000;
  localparam logic [31:0] CUR_PC     = 32'h0000_6000;

  localparam int STALL_NONE = 0;
  localparam int STALL_RAND = 1; // random id_ready_i and halt_if_i
  localparam int STALL_ID   = 2; // decode not ready
  localparam int STALL_HALT = 3; // fetch halted

  logic        clk;
  logic        rst_n;
  logic        req_i;
  logic        pc_set_i;
  pc_mux_e     pc_mux_i;
  exc_pc_mux_e exc_pc_mux_i;
  logic [31:0] boot_addr_i;
  trap_cfg_t   trap_cfg_i;
  jump_tgt_t   jump_tgt_i;
  ret_pc_t     ret_pc_i;
  logic        halt_if_i;
  logic        id_ready_i;
  logic        clear_instr_valid_i;
  instr_rsp_t  instr_rsp_i;
  instr_req_t  instr_req_o;
  if_id_t      if_id_o;
  logic [31:0] branch_target_o;
  logic        csr_mtvec_init_o;
  logic        if_busy_o;
  logic        perf_imiss_o;

  logic        mem_rand;     // memory delay mode
  logic [31:0] tgt_exp;      // target of the redirect being driven
  logic        boot_exp;     // boot redirect driven this cycle
  logic [31:0] exp_pc;       // address of the next word decode must see
  logic [31:0] rnd;
  int          out_cnt;      // granted requests without rvalid
  int          take_cnt;
  int          err_cnt;
  int          err_at_start;
  int          n_tests;
  int          stall_mode;
  string       test_name;
  logic        take;         // decode consumes the IF/ID word at this edge

  fetch_top #(.FIFO_DEPTH(FIFO_DEPTH)) fetch_top_inst (.*);

  tb_instr_mem #(.SEED(SEED), .DATA_XOR(DATA_XOR)) mem_inst (
    .clk         (clk),
    .rst_n       (rst_n),
    .rand_en_i   (mem_rand),
    .instr_req_i (instr_req_o),
    .instr_rsp_o (instr_rsp_i)
  );

  initial clk = 1'b0;
  always #(CLK_PERIOD / 2) clk = ~clk;

  // clear_instr_valid_i is raised exactly when decode takes the word or a redirect kills it
  assign take = if_id_o.valid && id_ready_i && clear_instr_valid_i && !pc_set_i;

  ////////////////////////////////////////////////////////////
  // reference model
  ////////////////////////////////////////////////////////////

  always @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      out_cnt  <= 0;
      exp_pc   <= 32'h0;
      take_cnt <= 0;
    end else begin
      out_cnt <= out_cnt + int'(instr_req_o.req && instr_rsp_i.gnt) - int'(instr_rsp_i.rvalid);
      if (pc_set_i) begin
        exp_pc <= {tgt_exp[31:2], 2'b00}; // fetch restarts word aligned
      end else if (take) begin
        exp_pc   <= exp_pc + 32'd4;
        take_cnt <= take_cnt + 1;
      end
    end
  end

  task automatic report_value(input string what, input logic [31:0] exp, input logic [31:0] act);
    err_cnt++;
    $display("CHECK FAILED test %s, %s: expected %08h, actual %08h", test_name, what, exp, act);
  endtask

  task automatic report_fault(input string what);
    err_cnt++;
    $display("ERROR in test %s: %s", test_name, what);
  endtask

  ////////////////////////////////////////////////////////////
  // checks
  ////////////////////////////////////////////////////////////

  a_instr_seq: assert property (@(posedge clk) disable iff (!rst_n)
    take |-> if_id_o.instr == (exp_pc ^ DATA_XOR))
    else report_value("instr", $sampled(exp_pc ^ DATA_XOR), $sampled(if_id_o.instr));

  a_target: assert property (@(posedge clk) disable iff (!rst_n)
    pc_set_i |-> branch_target_o == tgt_exp)
    else report_value("branch_target", $sampled(tgt_exp), $sampled(branch_target_o));

  a_mtvec_init: assert property (@(posedge clk) disable iff (!rst_n)
    csr_mtvec_init_o == boot_exp)
    else report_value("csr_mtvec_init", $sampled(boot_exp), $sampled(csr_mtvec_init_o));

  // redirect reaches the bus in the same cycle when a slot is free
  a_redirect_req: assert property (@(posedge clk) disable iff (!rst_n)
    pc_set_i && out_cnt < 2 |-> instr_req_o.req)
    else report_fault("no bus request in the redirect cycle");
  a_redirect_addr: assert property (@(posedge clk) disable iff (!rst_n)
    pc_set_i && out_cnt < 2 |-> instr_req_o.addr == {tgt_exp[31:2], 2'b00})
    else report_value("redirect addr", $sampled({tgt_exp[31:2], 2'b00}),
                      $sampled(instr_req_o.addr));

  a_outstanding: assert property (@(posedge clk) disable iff (!rst_n) out_cnt <= 2)
    else report_fault("more than two bus requests outstanding");

  a_hold: assert property (@(posedge clk) disable iff (!rst_n)
    if_id_o.valid && !clear_instr_valid_i && (!id_ready_i || halt_if_i) |=> $stable(if_id_o))
    else report_fault("IF/ID register changed while decode was stalled");

  a_clear: assert property (@(posedge clk) disable iff (!rst_n)
    clear_instr_valid_i && halt_if_i |=> !if_id_o.valid)
    else report_fault("IF/ID valid still high after clear_instr_valid_i");

  // words in flight or a word ready for decode keep the stage busy
  a_busy: assert property (@(posedge clk) disable iff (!rst_n)
    (out_cnt != 0 || !perf_imiss_o) |-> if_busy_o)
    else report_fault("if_busy_o low while words are in flight or buffered");

  // with decode taking words, IF/ID fills exactly when no miss is flagged
  a_imiss: assert property (@(posedge clk) disable iff (!rst_n)
    req_i && id_ready_i && !halt_if_i && clear_instr_valid_i |=>
      if_id_o.valid == !$past(perf_imiss_o))
    else report_fault("perf_imiss_o disagrees with the IF/ID load");

  ////////////////////////////////////////////////////////////
  // stimulus
  ////////////////////////////////////////////////////////////

  function automatic logic [31:0] lcg_next(input logic [31:0] s);
    return s * 32'd1664525 + 32'd1013904223;
  endfunction

  // one clock of inputs, called at a rising edge, returns at the next
  task automatic drive_cycle(input logic set, input pc_mux_e mux, input exc_pc_mux_e exc,
                             input logic [31:0] tgt, input logic clr);
    logic rdy;
    logic hlt;
    rdy = 1'b1;
    hlt = 1'b0;
    if (stall_mode == STALL_RAND) begin
      rnd = lcg_next(rnd);
      rdy = (rnd[21:20] != 2'b00);
      hlt = (rnd[24:22] == 3'b000);
    end else if (stall_mode == STALL_ID) begin
      rdy = 1'b0;
    end else if (stall_mode == STALL_HALT) begin
      hlt = 1'b1;
    end
    req_i    <= 1'b1;
    pc_set_i <= set;
    boot_exp <= set && (mux == PC_BOOT);
    if (set) begin
      pc_mux_i     <= mux;
      exc_pc_mux_i <= exc;
      tgt_exp      <= tgt;
    end
    id_ready_i          <= rdy;
    halt_if_i           <= hlt;
    clear_instr_valid_i <= set || clr || (rdy && !hlt); // word taken or killed
    @(posedge clk);
  endtask

  task automatic idle_cycles(input int n);
    repeat (n) drive_cycle(1'b0, PC_BOOT, EXC_PC_EXCEPTION, 32'h0, 1'b0);
  endtask

  task automatic wait_words(input int n);
    int target;
    target = take_cnt + n;
    while (take_cnt < target) begin
      idle_cycles(1); // watchdog bounds this
    end
  endtask

  task automatic redirect(input pc_mux_e mux, input exc_pc_mux_e exc, input logic [31:0] tgt);
    drive_cycle(1'b1, mux, exc, tgt, 1'b0);
    wait_words(3);
  endtask

  task automatic jump_to(input logic is_branch, input logic [31:0] tgt);
    if (is_branch) begin
      jump_tgt_i <= '{id_tgt: tgt ^ 32'h40, ex_tgt: tgt}; // wrong source gives other addr
    end else begin
      jump_tgt_i <= '{id_tgt: tgt, ex_tgt: tgt ^ 32'h40};
    end
    drive_cycle(1'b1, is_branch ? PC_BRANCH : PC_JUMP, EXC_PC_EXCEPTION, tgt, 1'b0);
  endtask

  task automatic start_test(input string name);
    test_name    = name;
    err_at_start = err_cnt;
  endtask

  task automatic end_test();
    n_tests++;
    $display("test %s done, %0d errors", test_name, err_cnt - err_at_start);
  endtask

  initial begin : main
    rst_n               = 1'b0;
    req_i               = 1'b0;
    pc_set_i            = 1'b0;
    pc_mux_i            = PC_BOOT;
    exc_pc_mux_i        = EXC_PC_EXCEPTION;
    boot_addr_i         = BOOT_ADDR;
    trap_cfg_i          = '{mtvec_base: MTVEC_BASE, vec_idx: VEC_IDX,
                            dm_halt: DM_HALT, dm_exc: DM_EXC};
    jump_tgt_i          = '0;
    ret_pc_i            = '{mepc: MEPC, depc: DEPC, pc: CUR_PC};
    halt_if_i           = 1'b0;
    id_ready_i          = 1'b0;
    clear_instr_valid_i = 1'b0;
    mem_rand            = 1'b0;
    tgt_exp             = 32'h0;
    boot_exp            = 1'b0;
    rnd                 = SEED;
    err_cnt             = 0;
    n_tests             = 0;
    stall_mode          = STALL_NONE;
    test_name           = "reset";
    repeat (RESET_CYC) @(posedge clk);
    rst_n <= 1'b1;

    start_test("boot"); // boot redirect comes with the first req_i
    drive_cycle(1'b1, PC_BOOT, EXC_PC_EXCEPTION, {BOOT_ADDR[31:2], 2'b00}, 1'b0);
    wait_words(8);
    end_test();

    start_test("redirect");
    mem_rand <= 1'b1;
    for (int i = 0; i < 8; i++) begin
      rnd = lcg_next(rnd);
      idle_cycles(int'(rnd[17:16])); // zero gap gives back to back redirects
      jump_to(i[0], 32'h0000_8000 + (32'(i) << 8));
    end
    wait_words(4);
    end_test();

    start_test("trap_ret");
    redirect(PC_EXCEPTION, EXC_PC_EXCEPTION, {MTVEC_BASE, 8'h00});
    redirect(PC_EXCEPTION, EXC_PC_IRQ, {MTVEC_BASE, 1'b0, VEC_IDX, 2'b00});
    redirect(PC_EXCEPTION, EXC_PC_DBD, {DM_HALT, 2'b00});
    redirect(PC_EXCEPTION, EXC_PC_DBE, {DM_EXC, 2'b00});
    redirect(PC_MRET, EXC_PC_EXCEPTION, MEPC);
    redirect(PC_DRET, EXC_PC_EXCEPTION, DEPC);
    redirect(PC_FENCEI, EXC_PC_EXCEPTION, CUR_PC + 32'd4);
    end_test();

    start_test("backpressure");
    stall_mode = STALL_ID;
    idle_cycles(10); // FIFO fills, req stops
    stall_mode = STALL_HALT;
    idle_cycles(10);
    stall_mode = STALL_NONE;
    wait_words(6);
    end_test();

    start_test("random");
    stall_mode = STALL_RAND;
    wait_words(200);
    stall_mode = STALL_NONE;
    end_test();

    start_test("clear_valid");
    wait_words(2);
    stall_mode = STALL_HALT;
    idle_cycles(3);
    drive_cycle(1'b0, PC_BOOT, EXC_PC_EXCEPTION, 32'h0, 1'b1); // clear pulse, nothing loads
    stall_mode = STALL_NONE;
    wait_words(4);
    end_test();

    $display("summary: %0d tests, %0d words checked, %0d errors", n_tests, take_cnt, err_cnt);
    if (err_cnt == 0) begin
      $display("=== PASS ===");
    end else begin
      $display("=== FAIL ===");
    end
    $finish;
  end

  initial begin : watchdog
    #((TEST_WORDS * WORST_CYC + RESET_CYC) * CLK_PERIOD);
    $display("watchdog timeout, fetch stream stalled after %0d words in test %s",
             take_cnt, test_name);
    $display("=== FAIL ===");
    $finish;
  end

endmodule

// File: sim/tb_instr_mem.sv
// instruction memory model; data is addr ^ DATA_XOR, responses in order, random gnt and latency
`timescale 1ns/100ps

module tb_instr_mem #(
  parameter logic [31:0] SEED     = 32'h3a3d,
  parameter logic [31:0] DATA_XOR = 32'hA5A5_0000
) (
  input  logic                  clk,
  input  logic                  rst_n,
  input  logic                  rand_en_i,   // random gnt and response delay, else 1 cycle
  input  fetch_pkg::instr_req_t instr_req_i,
  output fetch_pkg::instr_rsp_t instr_rsp_o
);

  import fetch_pkg::*;

  logic [31:0] rnd;
  int          cyc;
  logic [31:0] addr_q[$]; // granted addresses, oldest first
  int          due_q[$];  // earliest cycle for each response

  function automatic logic [31:0] lcg_step(input logic [31:0] s);
    return s * 32'd1664525 + 32'd1013904223;
  endfunction

  always @(posedge clk or negedge rst_n) begin : mem_model
    logic [31:0] delay;
    if (!rst_n) begin
      rnd = SEED;
      cyc = 0;
      addr_q.delete();
      due_q.delete();
      instr_rsp_o <= '0;
    end else begin
      rnd   = lcg_step(rnd);
      delay = rand_en_i ? {30'd0, rnd[17:16]} : 32'd0; // 0..3 extra cycles
      if (instr_req_i.req && instr_rsp_o.gnt) begin   // handshake seen by the DUT at this edge
        addr_q.push_back(instr_req_i.addr);
        due_q.push_back(cyc + int'(delay));
      end
      // only the head may answer, so order holds even with uneven delays
      if (addr_q.size() != 0 && due_q[0] <= cyc) begin
        instr_rsp_o.rvalid <= 1'b1;
        instr_rsp_o.rdata  <= addr_q[0] ^ DATA_XOR;
        void'(addr_q.pop_front());
        void'(due_q.pop_front());
      end else begin
        instr_rsp_o.rvalid <= 1'b0;
        instr_rsp_o.rdata  <= 32'h0;
      end
      instr_rsp_o.gnt <= rand_en_i ? (rnd[25:24] != 2'b00) : 1'b1; // gnt 3 of 4 cycles
      cyc = cyc + 1;
    end
  end

endmodule

// File: src/fetch_fifo.sv
// instruction word FIFO, FIFO_DEPTH >= 2; flush has priority over push and pop, data not reset
`timescale 1ns/100ps

module fetch_fifo #(
  parameter int FIFO_DEPTH = fetch_pkg::FIFO_DEPTH_DEF
) (
  input  logic                            clk,
  input  logic                            rst_n,
  input  logic                            flush_i,
  input  logic                            push_i,
  input  logic [31:0]                     push_data_i,
  input  logic                            pop_i,
  output logic                            valid_o,
  output logic [31:0]                     rdata_o,
  output logic [$clog2(FIFO_DEPTH+1)-1:0] cnt_o    // occupancy, lets the controller keep room
);

  localparam int PTR_W = $clog2(FIFO_DEPTH);
  localparam int CNT_W = $clog2(FIFO_DEPTH + 1);

  logic [31:0]      mem_q [FIFO_DEPTH];
  logic [PTR_W-1:0] rptr_q, wptr_q;
  logic [CNT_W-1:0] cnt_q;
  logic             do_push, do_pop;

  assign do_push = push_i & ~flush_i; // words arriving with a flush are stale
  assign do_pop  = pop_i & ~flush_i;

  // storage, write side only
  always_ff @(posedge clk) begin
    if (do_push) begin
      mem_q[wptr_q] <= push_data_i;
    end
  end

  // pointers and occupancy
  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      rptr_q <= '0;
      wptr_q <= '0;
      cnt_q  <= '0;
    end else if (flush_i) begin
      rptr_q <= '0; // empty in one cycle
      wptr_q <= '0;
      cnt_q  <= '0;
    end else begin
      if (do_push) begin
        wptr_q <= (wptr_q == PTR_W'(FIFO_DEPTH - 1)) ? '0 : wptr_q + 1'b1; // wrap for any depth
      end
      if (do_pop) begin
        rptr_q <= (rptr_q == PTR_W'(FIFO_DEPTH - 1)) ? '0 : rptr_q + 1'b1;
      end
      cnt_q <= cnt_q + CNT_W'(do_push) - CNT_W'(do_pop);
    end
  end

  assign valid_o = (cnt_q != '0);
  assign rdata_o = mem_q[rptr_q]; // head word, no fall-through
  assign cnt_o   = cnt_q;

  a_no_push_full: assert property (@(posedge clk) disable iff (!rst_n)
    do_push |-> (cnt_q < CNT_W'(FIFO_DEPTH)) || do_pop) else $error("push into full FIFO");
  a_no_pop_empty: assert property (@(posedge clk) disable iff (!rst_n)
    do_pop |-> valid_o) else $error("pop from empty FIFO");

endmodule

// File: src/fetch_pkg.sv
// shared fetch types and constants; 32-bit word fetch only, no compressed or misaligned instructions
package fetch_pkg;

  //////////////////////////////////////////////////////////
  // address select encodings
  //////////////////////////////////////////////////////////

  typedef enum logic [3:0] {
    PC_BOOT      = 4'b0000,
    PC_FENCEI    = 4'b0001, // refetch from pc + 4
    PC_JUMP      = 4'b0010, // id-stage jump
    PC_BRANCH    = 4'b0011, // ex-stage branch
    PC_EXCEPTION = 4'b0100, // target comes from exc_pc_mux_e
    PC_MRET      = 4'b0101,
    PC_DRET      = 4'b0111
  } pc_mux_e;

  typedef enum logic [2:0] {
    EXC_PC_EXCEPTION = 3'b000, // trap base, all causes share it
    EXC_PC_IRQ       = 3'b001, // vectored by interrupt index
    EXC_PC_DBD       = 3'b010, // debug halt entry
    EXC_PC_DBE       = 3'b100  // debug exception entry
  } exc_pc_mux_e;

  //////////////////////////////////////////////////////////
  // bus and pipeline bundles
  //////////////////////////////////////////////////////////

  typedef struct packed {
    logic        req;
    logic [31:0] addr;
  } instr_req_t; // fetch side -> memory

  typedef struct packed {
    logic        gnt;
    logic        rvalid;
    logic [31:0] rdata;
  } instr_rsp_t; // memory -> fetch side

  typedef struct packed {
    logic        valid;
    logic [31:0] instr;
  } if_id_t;

  typedef struct packed {
    logic [31:0] id_tgt; // jump target from id
    logic [31:0] ex_tgt; // branch target from ex
  } jump_tgt_t;

  typedef struct packed {
    logic [31:0] mepc;
    logic [31:0] depc;
    logic [31:0] pc;     // pc of the current instruction, used by fence.i
  } ret_pc_t;

  typedef struct packed {
    logic [23:0] mtvec_base; // machine trap base, upper bits
    logic [4:0]  vec_idx;    // interrupt vector index
    logic [29:0] dm_halt;    // debug halt address [31:2]
    logic [29:0] dm_exc;     // debug exception address [31:2]
  } trap_cfg_t;

  localparam int          FIFO_DEPTH_DEF = 2;
  localparam logic [31:0] RESET_ADDR     = 32'h0000_0080; // fetch address held until first branch

endpackage

// File: src/fetch_top.sv
// fetch front end top; FIFO_DEPTH >= 2, drive pc_set_i with PC_BOOT together with the first req_i
`timescale 1ns/100ps

module fetch_top #(
  parameter int FIFO_DEPTH = fetch_pkg::FIFO_DEPTH_DEF
) (
  input  logic                   clk,
  input  logic                   rst_n,
  input  logic                   req_i,
  input  logic                   pc_set_i,
  input  fetch_pkg::pc_mux_e     pc_mux_i,
  input  fetch_pkg::exc_pc_mux_e exc_pc_mux_i,
  input  logic [31:0]            boot_addr_i,
  input  fetch_pkg::trap_cfg_t   trap_cfg_i,
  input  fetch_pkg::jump_tgt_t   jump_tgt_i,
  input  fetch_pkg::ret_pc_t     ret_pc_i,
  input  logic                   halt_if_i,
  input  logic                   id_ready_i,
  input  logic                   clear_instr_valid_i,
  input  fetch_pkg::instr_rsp_t  instr_rsp_i,        // memory side: gnt, rvalid, rdata
  output fetch_pkg::instr_req_t  instr_req_o,
  output fetch_pkg::if_id_t      if_id_o,            // to decode
  output logic [31:0]            branch_target_o,
  output logic                   csr_mtvec_init_o,
  output logic                   if_busy_o,
  output logic                   perf_imiss_o
);

  if_stage #(.FIFO_DEPTH(FIFO_DEPTH)) if_stage_inst (
    .clk (clk), .rst_n (rst_n), .req_i (req_i), .pc_set_i (pc_set_i),
    .pc_mux_i (pc_mux_i), .exc_pc_mux_i (exc_pc_mux_i), .boot_addr_i (boot_addr_i),
    .trap_cfg_i (trap_cfg_i), .jump_tgt_i (jump_tgt_i), .ret_pc_i (ret_pc_i),
    .halt_if_i (halt_if_i), .id_ready_i (id_ready_i),
    .clear_instr_valid_i (clear_instr_valid_i), .instr_rsp_i (instr_rsp_i),
    .instr_req_o (instr_req_o), .if_id_o (if_id_o), .branch_target_o (branch_target_o),
    .csr_mtvec_init_o (csr_mtvec_init_o), .if_busy_o (if_busy_o),
    .perf_imiss_o (perf_imiss_o)
  );

endmodule

// File: src/if_stage.sv
// fetch stage, PC select and IF/ID register; branch targets are used word aligned, no compressed
`timescale 1ns/100ps

module if_stage #(
  parameter int FIFO_DEPTH = fetch_pkg::FIFO_DEPTH_DEF
) (
  input  logic                   clk,
  input  logic                   rst_n,
  input  logic                   req_i,               // core wants instructions
  input  logic                   pc_set_i,
  input  fetch_pkg::pc_mux_e     pc_mux_i,
  input  fetch_pkg::exc_pc_mux_e exc_pc_mux_i,
  input  logic [31:0]            boot_addr_i,
  input  fetch_pkg::trap_cfg_t   trap_cfg_i,
  input  fetch_pkg::jump_tgt_t   jump_tgt_i,
  input  fetch_pkg::ret_pc_t     ret_pc_i,
  input  logic                   halt_if_i,
  input  logic                   id_ready_i,
  input  logic                   clear_instr_valid_i,
  input  fetch_pkg::instr_rsp_t  instr_rsp_i,
  output fetch_pkg::instr_req_t  instr_req_o,
  output fetch_pkg::if_id_t      if_id_o,
  output logic [31:0]            branch_target_o,
  output logic                   csr_mtvec_init_o,
  output logic                   if_busy_o,
  output logic                   perf_imiss_o
);

  import fetch_pkg::*;

  typedef enum logic {IDLE, WAIT} offset_state_e;

  offset_state_e ofs_q, ofs_n;
  logic [31:0]   exc_pc;
  logic [31:0]   fetch_addr_n;
  logic          branch_req;
  logic          fetch_valid, fetch_ready;
  logic [31:0]   fetch_rdata;
  logic          id_valid_q;
  logic [31:0]   id_instr_q;

  //////////////////////////////////////////////////////////
  // target address selection
  //////////////////////////////////////////////////////////

  always_comb begin : exc_pc_mux
    unique case (exc_pc_mux_i)
      EXC_PC_EXCEPTION: exc_pc = {trap_cfg_i.mtvec_base, 8'h00};
      EXC_PC_IRQ:       exc_pc = {trap_cfg_i.mtvec_base, 1'b0, trap_cfg_i.vec_idx, 2'b00};
      EXC_PC_DBD:       exc_pc = {trap_cfg_i.dm_halt, 2'b00};
      EXC_PC_DBE:       exc_pc = {trap_cfg_i.dm_exc, 2'b00};
      default:          exc_pc = {trap_cfg_i.mtvec_base, 8'h00};
    endcase
  end

  always_comb begin : pc_mux
    unique case (pc_mux_i)
      PC_BOOT:      fetch_addr_n = {boot_addr_i[31:2], 2'b00};
      PC_JUMP:      fetch_addr_n = jump_tgt_i.id_tgt;
      PC_BRANCH:    fetch_addr_n = jump_tgt_i.ex_tgt;
      PC_EXCEPTION: fetch_addr_n = exc_pc;
      PC_MRET:      fetch_addr_n = ret_pc_i.mepc;
      PC_DRET:      fetch_addr_n = ret_pc_i.depc;
      PC_FENCEI:    fetch_addr_n = ret_pc_i.pc + 32'd4; // reload the buffer past fence.i
      default:      fetch_addr_n = {boot_addr_i[31:2], 2'b00};
    endcase
  end

  assign branch_target_o  = fetch_addr_n;
  assign csr_mtvec_init_o = pc_set_i && (pc_mux_i == PC_BOOT); // boot initialises mtvec

  prefetch_buffer #(.FIFO_DEPTH(FIFO_DEPTH)) prefetch_buffer_inst (
    .clk           (clk),
    .rst_n         (rst_n),
    .req_i         (req_i),
    .branch_i      (branch_req),
    .branch_addr_i ({fetch_addr_n[31:2], 2'b00}),
    .fetch_ready_i (fetch_ready),
    .instr_rsp_i   (instr_rsp_i),
    .fetch_valid_o (fetch_valid),
    .fetch_rdata_o (fetch_rdata),
    .instr_req_o   (instr_req_o),
    .busy_o        (if_busy_o)
  );

  //////////////////////////////////////////////////////////
  // offset FSM
  //////////////////////////////////////////////////////////

  always_comb begin
    ofs_n       = ofs_q;
    branch_req  = 1'b0;
    fetch_ready = 1'b0;
    unique case (ofs_q)
      IDLE: begin
        if (req_i) begin
          branch_req = 1'b1; // first fetch after reset
          ofs_n      = WAIT;
        end
      end
      WAIT: begin
        if (fetch_valid && req_i && id_ready_i && !halt_if_i) begin
          fetch_ready = 1'b1; // word moves into IF/ID
        end
      end
      default: ofs_n = IDLE;
    endcase
    if (pc_set_i) begin
      fetch_ready = 1'b0; // head word is stale
      branch_req  = 1'b1;
      ofs_n       = WAIT;
    end
  end

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      ofs_q <= IDLE;
    end else begin
      ofs_q <= ofs_n;
    end
  end

  // IF/ID register, frozen while decode stalls
  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      id_valid_q <= 1'b0;
    end else if (fetch_ready) begin
      id_valid_q <= 1'b1;
    end else if (clear_instr_valid_i) begin
      id_valid_q <= 1'b0;
    end
  end

  always_ff @(posedge clk) begin
    if (fetch_ready) begin
      id_instr_q <= fetch_rdata;
    end
  end

  assign if_id_o      = '{valid: id_valid_q, instr: id_instr_q};
  assign perf_imiss_o = !fetch_valid || branch_req;

  a_pc_mux_known: assert property (@(posedge clk) disable iff (!rst_n)
    pc_set_i |-> !$isunknown(pc_mux_i)) else $error("pc_mux_i unknown on pc_set_i");
  a_id_hold: assert property (@(posedge clk) disable iff (!rst_n)
    if_id_o.valid && !id_ready_i |=> $stable(if_id_o.instr))
    else $error("IF/ID instr changed while decode stalled");

endmodule

// File: src/prefetch_buffer.sv
// prefetch buffer, controller plus word FIFO; responses are never back-pressured
`timescale 1ns/100ps

module prefetch_buffer #(
  parameter int FIFO_DEPTH = fetch_pkg::FIFO_DEPTH_DEF
) (
  input  logic                  clk,
  input  logic                  rst_n,
  input  logic                  req_i,
  input  logic                  branch_i,       // flush and refetch from branch_addr_i
  input  logic [31:0]           branch_addr_i,
  input  logic                  fetch_ready_i,  // fetch stage takes the head word
  input  fetch_pkg::instr_rsp_t instr_rsp_i,
  output logic                  fetch_valid_o,
  output logic [31:0]           fetch_rdata_o,
  output fetch_pkg::instr_req_t instr_req_o,
  output logic                  busy_o
);

  localparam int CNT_W = $clog2(FIFO_DEPTH + 1);

  logic [CNT_W-1:0] fifo_cnt;
  logic [1:0]       outstanding;
  logic             resp_valid;

  prefetch_ctrl #(.FIFO_DEPTH(FIFO_DEPTH)) prefetch_ctrl_inst (
    .clk           (clk),
    .rst_n         (rst_n),
    .req_i         (req_i),
    .branch_i      (branch_i),
    .branch_addr_i (branch_addr_i),
    .fifo_cnt_i    (fifo_cnt),
    .instr_rsp_i   (instr_rsp_i),
    .instr_req_o   (instr_req_o),
    .resp_valid_o  (resp_valid),
    .outstanding_o (outstanding)
  );

  fetch_fifo #(.FIFO_DEPTH(FIFO_DEPTH)) fetch_fifo_inst (
    .clk         (clk),
    .rst_n       (rst_n),
    .flush_i     (branch_i),
    .push_i      (resp_valid),        // only words of the current stream
    .push_data_i (instr_rsp_i.rdata),
    .pop_i       (fetch_ready_i),
    .valid_o     (fetch_valid_o),
    .rdata_o     (fetch_rdata_o),
    .cnt_o       (fifo_cnt)
  );

  assign busy_o = (outstanding != 2'd0) || (fifo_cnt != '0); // still fetching or holding words

endmodule

// File: src/prefetch_ctrl.sv
// bus request FSM; max two requests in flight, a branch may redirect a request not yet granted
`timescale 1ns/100ps

module prefetch_ctrl #(
  parameter int FIFO_DEPTH = fetch_pkg::FIFO_DEPTH_DEF
) (
  input  logic                            clk,
  input  logic                            rst_n,
  input  logic                            req_i,
  input  logic                            branch_i,
  input  logic [31:0]                     branch_addr_i,
  input  logic [$clog2(FIFO_DEPTH+1)-1:0] fifo_cnt_i,
  input  fetch_pkg::instr_rsp_t           instr_rsp_i,
  output fetch_pkg::instr_req_t           instr_req_o,
  output logic                            resp_valid_o,  // rvalid that belongs to the current stream
  output logic [1:0]                      outstanding_o
);

  import fetch_pkg::*;

  typedef enum logic {IDLE, BLOCKED} ctrl_state_e; // BLOCKED: req presented, waiting for gnt

  ctrl_state_e state_q, state_n;
  logic [31:0] addr_q, addr_n;       // next sequential fetch address
  logic [1:0]  outst_q, outst_n;     // granted but not yet answered
  logic [1:0]  discard_q, discard_n; // stale responses still to drop
  logic        room;
  logic        accepted;
  logic        rvalid;

  assign rvalid = instr_rsp_i.rvalid;

  // a new request needs a bus slot and FIFO room for all words in flight,
  // on a branch the FIFO is flushed so only the bus limit counts
  assign room = (outst_q < 2'd2) &&
                (branch_i || ((32'(outst_q) + 32'(fifo_cnt_i)) < 32'(FIFO_DEPTH)));

  always_comb begin
    instr_req_o.addr = branch_i ? branch_addr_i : addr_q; // branch target goes out at once
    instr_req_o.req  = (state_q == BLOCKED) || ((req_i || branch_i) && room);
  end

  assign accepted = instr_req_o.req & instr_rsp_i.gnt;

  always_comb begin
    state_n   = (instr_req_o.req && !instr_rsp_i.gnt) ? BLOCKED : IDLE;
    addr_n    = addr_q;
    outst_n   = outst_q + {1'b0, accepted} - {1'b0, rvalid};
    discard_n = discard_q;
    if (accepted) begin
      addr_n = instr_req_o.addr + 32'd4;
    end else if (branch_i) begin
      addr_n = branch_addr_i; // issue later, bus slots busy
    end
    if (branch_i) begin
      discard_n = outst_q - {1'b0, rvalid}; // everything before the branch is stale
    end else if (rvalid && (discard_q != 2'd0)) begin
      discard_n = discard_q - 2'd1;
    end
  end

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      state_q   <= IDLE;
      addr_q    <= RESET_ADDR;
      outst_q   <= 2'd0;
      discard_q <= 2'd0;
    end else begin
      state_q   <= state_n;
      addr_q    <= addr_n;
      outst_q   <= outst_n;
      discard_q <= discard_n;
    end
  end

  assign resp_valid_o  = rvalid && !branch_i && (discard_q == 2'd0);
  assign outstanding_o = outst_q;

  a_outst_max: assert property (@(posedge clk) disable iff (!rst_n)
    outst_q <= 2'd2) else $error("more than two requests outstanding");

  // req holds with a stable addr until gnt, unless a branch redirects it
  a_addr_stable: assert property (@(posedge clk) disable iff (!rst_n)
    instr_req_o.req && !instr_rsp_i.gnt |=>
      instr_req_o.req && (branch_i || $stable(instr_req_o.addr)))
    else $error("instr addr changed before gnt");

endmodule
